// ==== hdl/tomasulo_cfg.svh ====
`ifndef TOMASULO_CFG_SVH
`define TOMASULO_CFG_SVH

// datapath width
`define XLEN 32

// reorder buffer, one tag per entry
`define TAG_W 3
`define NUM_TAGS 8

// architectural registers, r0 is hardwired zero
`define REG_W 3
`define NUM_REGS 8

// stations, one alu lane each
`define NUM_RS 2

`endif

// ==== hdl/tomasulo_pkg.sv ====
`include "tomasulo_cfg.svh"

package tomasulo_pkg;

    // source of operand 2
    typedef enum logic {
        REG_OP = 1'b0,
        IMM_OP = 1'b1
    } alu_op_e;

    // instruction as delivered by the source
    typedef struct packed {
        alu_op_e            op;
        logic [2:0]         funct3;
        // sub / sra select
        logic               funct7;
        logic [`REG_W-1:0]  rd;
        logic [`REG_W-1:0]  rs1;
        logic [`REG_W-1:0]  rs2;
        logic [`XLEN-1:0]   imm;
    } instr_t;

    // station entry, tag is only meaningful while valid is low
    typedef struct packed {
        alu_op_e            op;
        logic [2:0]         funct3;
        logic               funct7;
        logic [`TAG_W-1:0]  src1_tag;
        logic [`XLEN-1:0]   src1_data;
        logic               src1_valid;
        logic [`TAG_W-1:0]  src2_tag;
        logic [`XLEN-1:0]   src2_data;
        logic               src2_valid;
        logic [`TAG_W-1:0]  rd_tag;
    } res_word_t;

    // station to lane
    typedef struct packed {
        alu_op_e            op;
        logic [2:0]         funct3;
        logic               funct7;
        logic [`XLEN-1:0]   src1_data;
        logic [`XLEN-1:0]   src2_data;
        logic [`TAG_W-1:0]  tag;
    } alu_word_t;

    // one bus slot per rob entry, ready bit lives in robs_calculated
    typedef struct packed {
        logic [`XLEN-1:0]   data;
    } cdb_data_t;

    // lane output
    typedef struct packed {
        logic               valid;
        logic [`TAG_W-1:0]  tag;
        logic [`XLEN-1:0]   data;
    } result_t;

    // in-order retirement record
    typedef struct packed {
        logic               valid;
        logic [`REG_W-1:0]  rd;
        logic [`XLEN-1:0]   data;
    } commit_t;

endpackage : tomasulo_pkg

// ==== hdl/dispatch_unit.sv ====
`timescale 1ns/1ps
`include "tomasulo_cfg.svh"

module dispatch_unit (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    instr_req,
    input  tomasulo_pkg::instr_t    instr,
    input  logic                    res_empty [`NUM_RS],
    input  logic                    rob_full,
    input  logic [`TAG_W-1:0]       rob_tail,
    input  tomasulo_pkg::cdb_data_t cdb [`NUM_TAGS],
    input  logic [`NUM_TAGS-1:0]    robs_calculated,
    input  tomasulo_pkg::commit_t   retire,
    output logic                    instr_ack,
    output logic                    load_word [`NUM_RS],
    output tomasulo_pkg::res_word_t res_in [`NUM_RS],
    output logic                    rob_alloc,
    output logic [`REG_W-1:0]       alloc_rd
);
    import tomasulo_pkg::*;

    // architectural state
    logic [`XLEN-1:0]     regs [`NUM_REGS];
    logic [`NUM_REGS-1:0] busy;
    logic [`TAG_W-1:0]    stat_tag [`NUM_REGS];

    // tag of the next entry to retire, tracks the rob head
    logic [`TAG_W-1:0]    head_tag;

    logic                 ack_hold;
    logic                 accept;
    logic                 any_empty;
    logic                 pick [`NUM_RS];
    res_word_t            new_word;
    res_word_t            held [`NUM_RS];

    // returns {valid, tag, data} for one source register
    function automatic logic [`XLEN+`TAG_W:0] lookup(input logic [`REG_W-1:0] rs);
        logic [`TAG_W-1:0] tag;
        tag = stat_tag[rs];
        if (rs == '0)
            return {1'b1, {`TAG_W{1'b0}}, {`XLEN{1'b0}}};
        if (!busy[rs])
            return {1'b1, tag, regs[rs]};
        // producer done but not yet retired
        if (robs_calculated[tag])
            return {1'b1, tag, cdb[tag].data};
        return {1'b0, tag, {`XLEN{1'b0}}};
    endfunction

    // lowest numbered empty station wins
    always_comb begin
        any_empty = 1'b0;
        for (int i = 0; i < `NUM_RS; i++) begin
            pick[i] = res_empty[i] && !any_empty;
            any_empty = any_empty | res_empty[i];
        end
    end

    // one acceptance per req pulse
    assign accept    = instr_req && !ack_hold && any_empty && !rob_full;
    assign instr_ack = accept || ack_hold;
    assign rob_alloc = accept;
    assign alloc_rd  = instr.rd;

    // issue word for the incoming instruction
    always_comb begin
        new_word.op     = instr.op;
        new_word.funct3 = instr.funct3;
        new_word.funct7 = instr.funct7;
        {new_word.src1_valid, new_word.src1_tag, new_word.src1_data} = lookup(instr.rs1);
        if (instr.op == IMM_OP) begin
            // immediate is always ready
            new_word.src2_valid = 1'b1;
            new_word.src2_tag   = '0;
            new_word.src2_data  = instr.imm;
        end else begin
            {new_word.src2_valid, new_word.src2_tag, new_word.src2_data} = lookup(instr.rs2);
        end
        new_word.rd_tag = rob_tail;
    end

    // per station word, pending operands refreshed from the bus
    always_comb begin
        for (int i = 0; i < `NUM_RS; i++) begin
            load_word[i] = accept && pick[i];
            res_in[i]    = held[i];
            if (!held[i].src1_valid && robs_calculated[held[i].src1_tag]) begin
                res_in[i].src1_valid = 1'b1;
                res_in[i].src1_data  = cdb[held[i].src1_tag].data;
            end
            if (!held[i].src2_valid && robs_calculated[held[i].src2_tag]) begin
                res_in[i].src2_valid = 1'b1;
                res_in[i].src2_data  = cdb[held[i].src2_tag].data;
            end
            // station latches this in the load cycle
            if (load_word[i])
                res_in[i] = new_word;
        end
    end

    // handshake, register file and busy bits
    always_ff @(posedge clk) begin
        if (rst) begin
            ack_hold <= 1'b0;
            busy     <= '0;
            head_tag <= '0;
            for (int r = 0; r < `NUM_REGS; r++)
                regs[r] <= '0;
        end else begin
            if (accept)
                ack_hold <= 1'b1;
            else if (!instr_req)
                ack_hold <= 1'b0;

            if (retire.valid) begin
                head_tag <= head_tag + 1'b1;
                if (retire.rd != '0)
                    regs[retire.rd] <= retire.data;
                // only the newest writer of rd frees it
                if (busy[retire.rd] && stat_tag[retire.rd] == head_tag)
                    busy[retire.rd] <= 1'b0;
            end

            // rename wins over a same-cycle retire
            if (accept && instr.rd != '0)
                busy[instr.rd] <= 1'b1;
        end
    end

    // rename tags and held station words
    always_ff @(posedge clk) begin
        if (accept)
            stat_tag[instr.rd] <= rob_tail;
        for (int i = 0; i < `NUM_RS; i++)
            if (load_word[i])
                held[i] <= new_word;
    end

endmodule : dispatch_unit

// ==== hdl/reservation_station.sv ====
`timescale 1ns/1ps
`include "tomasulo_cfg.svh"

module reservation_station (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    load_word,
    input  tomasulo_pkg::cdb_data_t cdb [`NUM_TAGS],
    input  logic [`NUM_TAGS-1:0]    robs_calculated,
    input  tomasulo_pkg::res_word_t res_in,
    output tomasulo_pkg::alu_word_t alu_data,
    output logic                    start_exe,
    output logic                    res_empty
);
    import tomasulo_pkg::*;

    typedef enum logic [1:0] {
        EMPTY,
        CHECK,
        PEEK_ONE,
        PEEK_REST
    } state_e;

    state_e           state;
    res_word_t        res_word;

    // {valid, data} of each operand as seen this cycle
    logic [`XLEN:0]   opnd1;
    logic [`XLEN:0]   opnd2;

    // held value first, then dispatch word, then bus slot of the tag
    function automatic logic [`XLEN:0] resolve(
        input state_e            st,
        input logic              held_v,
        input logic [`XLEN-1:0]  held_d,
        input logic              in_v,
        input logic [`XLEN-1:0]  in_d,
        input logic [`TAG_W-1:0] tag
    );
        if (held_v)
            return {1'b1, held_d};
        // dispatch word only during CHECK and PEEK_ONE
        if (st != PEEK_REST && in_v)
            return {1'b1, in_d};
        if (st != CHECK && robs_calculated[tag])
            return {1'b1, cdb[tag].data};
        return {1'b0, held_d};
    endfunction

    always_comb begin
        opnd1 = resolve(state, res_word.src1_valid, res_word.src1_data,
                        res_in.src1_valid, res_in.src1_data, res_word.src1_tag);
        opnd2 = resolve(state, res_word.src2_valid, res_word.src2_data,
                        res_in.src2_valid, res_in.src2_data, res_word.src2_tag);
    end

    // fire in the cycle the last operand shows up
    assign start_exe = (state != EMPTY) && opnd1[`XLEN] && opnd2[`XLEN];
    assign res_empty = (state == EMPTY);

    always_comb begin
        alu_data.op        = res_word.op;
        alu_data.funct3    = res_word.funct3;
        alu_data.funct7    = res_word.funct7;
        alu_data.src1_data = opnd1[`XLEN-1:0];
        alu_data.src2_data = opnd2[`XLEN-1:0];
        alu_data.tag       = res_word.rd_tag;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= EMPTY;
        end else begin
            case (state)
                EMPTY: begin
                    if (load_word)
                        state <= CHECK;
                end
                CHECK: begin
                    state <= start_exe ? EMPTY : PEEK_ONE;
                end
                default: begin
                    state <= start_exe ? EMPTY : PEEK_REST;
                end
            endcase
        end
    end

    // entry payload
    always_ff @(posedge clk) begin
        if (state == EMPTY) begin
            if (load_word)
                res_word <= res_in;
        end else begin
            // keep whatever was captured while waiting
            res_word.src1_valid <= opnd1[`XLEN];
            res_word.src1_data  <= opnd1[`XLEN-1:0];
            res_word.src2_valid <= opnd2[`XLEN];
            res_word.src2_data  <= opnd2[`XLEN-1:0];
        end
    end

endmodule : reservation_station

// ==== hdl/reorder_buffer.sv ====
`timescale 1ns/1ps
`include "tomasulo_cfg.svh"

module reorder_buffer (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    rob_alloc,
    input  logic [`REG_W-1:0]       alloc_rd,
    input  tomasulo_pkg::result_t   results [`NUM_RS],
    output logic [`TAG_W-1:0]       rob_tail,
    output logic                    rob_full,
    output tomasulo_pkg::cdb_data_t cdb [`NUM_TAGS],
    output logic [`NUM_TAGS-1:0]    robs_calculated,
    output tomasulo_pkg::commit_t   retire,
    output tomasulo_pkg::commit_t   commit
);
    import tomasulo_pkg::*;

    // per-tag storage
    logic [`REG_W-1:0] rd_q [`NUM_TAGS];
    logic [`XLEN-1:0]  data_q [`NUM_TAGS];

    logic [`TAG_W-1:0] head;
    logic [`TAG_W:0]   count;
    logic              retire_now;

    assign rob_full   = (count == `NUM_TAGS);
    assign retire_now = (count != '0) && robs_calculated[head];

    // result storage doubles as the bus
    always_comb begin
        for (int i = 0; i < `NUM_TAGS; i++)
            cdb[i].data = data_q[i];
    end

    always_ff @(posedge clk) begin
        retire.rd   <= rd_q[head];
        retire.data <= data_q[head];
        commit.rd   <= retire.rd;
        commit.data <= retire.data;
        if (rst) begin
            head            <= '0;
            rob_tail        <= '0;
            count           <= '0;
            robs_calculated <= '0;
            retire.valid    <= 1'b0;
            commit.valid    <= 1'b0;
        end else begin
            for (int i = 0; i < `NUM_RS; i++)
                if (results[i].valid)
                    robs_calculated[results[i].tag] <= 1'b1;
            if (rob_alloc) begin
                robs_calculated[rob_tail] <= 1'b0;
                rob_tail <= rob_tail + 1'b1;
            end
            // one retirement per cycle, oldest first
            if (retire_now)
                head <= head + 1'b1;
            count <= count + (`TAG_W+1)'(rob_alloc) - (`TAG_W+1)'(retire_now);
            retire.valid <= retire_now;
            commit.valid <= retire.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (rob_alloc)
            rd_q[rob_tail] <= alloc_rd;
        for (int i = 0; i < `NUM_RS; i++)
            if (results[i].valid)
                data_q[results[i].tag] <= results[i].data;
    end

endmodule : reorder_buffer

// ==== hdl/alu_unit.sv ====
`timescale 1ns/1ps
`include "tomasulo_cfg.svh"

module alu_unit (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    start_exe,
    input  tomasulo_pkg::alu_word_t alu_data,
    output tomasulo_pkg::result_t   result
);
    import tomasulo_pkg::*;

    logic [`XLEN-1:0]          a;
    logic [`XLEN-1:0]          b;
    logic [`XLEN-1:0]          y;
    logic [$clog2(`XLEN)-1:0]  shamt;

    always_comb begin
        a     = alu_data.src1_data;
        b     = alu_data.src2_data;
        shamt = b[$clog2(`XLEN)-1:0];
        case (alu_data.funct3)
            // sub only exists in register form
            3'b000: y = (alu_data.op == REG_OP && alu_data.funct7) ? a - b : a + b;
            3'b001: y = a << shamt;
            3'b010: y = {{(`XLEN-1){1'b0}}, $signed(a) < $signed(b)};
            3'b011: y = {{(`XLEN-1){1'b0}}, a < b};
            3'b100: y = a ^ b;
            // srl / sra
            3'b101: y = alu_data.funct7 ? $unsigned($signed(a) >>> shamt) : a >> shamt;
            3'b110: y = a | b;
            default: y = a & b;
        endcase
    end

    // one cycle lane
    always_ff @(posedge clk) begin
        result.tag  <= alu_data.tag;
        result.data <= y;
        if (rst)
            result.valid <= 1'b0;
        else
            result.valid <= start_exe;
    end

endmodule : alu_unit

// ==== hdl/tomasulo_core.sv ====
`timescale 1ns/1ps
`include "tomasulo_cfg.svh"

module tomasulo_core (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  instr_req,
    input  tomasulo_pkg::instr_t  instr,
    output logic                  instr_ack,
    output tomasulo_pkg::commit_t commit
);
    import tomasulo_pkg::*;

    // dispatch to stations
    logic                 res_empty [`NUM_RS];
    logic                 load_word [`NUM_RS];
    res_word_t            res_in [`NUM_RS];

    // stations to lanes to rob
    alu_word_t            alu_data [`NUM_RS];
    logic                 start_exe [`NUM_RS];
    result_t              results [`NUM_RS];

    // rob side
    logic                 rob_alloc;
    logic [`REG_W-1:0]    alloc_rd;
    logic [`TAG_W-1:0]    rob_tail;
    logic                 rob_full;
    cdb_data_t            cdb [`NUM_TAGS];
    logic [`NUM_TAGS-1:0] robs_calculated;
    commit_t              retire;

    dispatch_unit dispatch_unit_inst (
        .clk             (clk),
        .rst             (rst),
        .instr_req       (instr_req),
        .instr           (instr),
        .res_empty       (res_empty),
        .rob_full        (rob_full),
        .rob_tail        (rob_tail),
        .cdb             (cdb),
        .robs_calculated (robs_calculated),
        .retire          (retire),
        .instr_ack       (instr_ack),
        .load_word       (load_word),
        .res_in          (res_in),
        .rob_alloc       (rob_alloc),
        .alloc_rd        (alloc_rd)
    );

    // each station owns one lane
    for (genvar i = 0; i < `NUM_RS; i++) begin : g_lane
        reservation_station reservation_station_inst (
            .clk             (clk),
            .rst             (rst),
            .load_word       (load_word[i]),
            .cdb             (cdb),
            .robs_calculated (robs_calculated),
            .res_in          (res_in[i]),
            .alu_data        (alu_data[i]),
            .start_exe       (start_exe[i]),
            .res_empty       (res_empty[i])
        );

        alu_unit alu_unit_inst (
            .clk       (clk),
            .rst       (rst),
            .start_exe (start_exe[i]),
            .alu_data  (alu_data[i]),
            .result    (results[i])
        );
    end

    reorder_buffer reorder_buffer_inst (
        .clk             (clk),
        .rst             (rst),
        .rob_alloc       (rob_alloc),
        .alloc_rd        (alloc_rd),
        .results         (results),
        .rob_tail        (rob_tail),
        .rob_full        (rob_full),
        .cdb             (cdb),
        .robs_calculated (robs_calculated),
        .retire          (retire),
        .commit          (commit)
    );

endmodule : tomasulo_core

// ==== bench/tomasulo_vectors.svh ====
// columns: op, funct3, funct7, rd, rs1, rs2, imm, expected commit data
// rows commit in this order, rd of the commit is the rd column
localparam int NUM_VEC = 33;
localparam int VEC_W   = $bits(instr_t) + `XLEN;

logic [VEC_W-1:0] vectors [NUM_VEC] = '{
    // seed values
    {IMM_OP, 3'b000, 1'b0, 3'd1, 3'd0, 3'd0, 32'h00000123, 32'h00000123},
    {IMM_OP, 3'b000, 1'b0, 3'd2, 3'd0, 3'd0, 32'hfffffffb, 32'hfffffffb},
    // register forms, every funct3 and funct7
    {REG_OP, 3'b000, 1'b0, 3'd3, 3'd1, 3'd2, 32'h00000000, 32'h0000011e},
    {REG_OP, 3'b000, 1'b1, 3'd4, 3'd1, 3'd2, 32'h00000000, 32'h00000128},
    {REG_OP, 3'b001, 1'b0, 3'd5, 3'd1, 3'd3, 32'h00000000, 32'hc0000000},
    {REG_OP, 3'b010, 1'b0, 3'd6, 3'd5, 3'd1, 32'h00000000, 32'h00000001},
    {REG_OP, 3'b011, 1'b0, 3'd7, 3'd5, 3'd1, 32'h00000000, 32'h00000000},
    {REG_OP, 3'b100, 1'b0, 3'd6, 3'd1, 3'd2, 32'h00000000, 32'hfffffed8},
    {REG_OP, 3'b101, 1'b0, 3'd7, 3'd5, 3'd6, 32'h00000000, 32'h000000c0},
    {REG_OP, 3'b101, 1'b1, 3'd7, 3'd5, 3'd6, 32'h00000000, 32'hffffffc0},
    {REG_OP, 3'b110, 1'b0, 3'd3, 3'd1, 3'd7, 32'h00000000, 32'hffffffe3},
    {REG_OP, 3'b111, 1'b0, 3'd4, 3'd3, 3'd2, 32'h00000000, 32'hffffffe3},
    // immediate forms
    {IMM_OP, 3'b001, 1'b0, 3'd5, 3'd1, 3'd0, 32'h00000004, 32'h00001230},
    {IMM_OP, 3'b010, 1'b0, 3'd6, 3'd2, 3'd0, 32'hffffffff, 32'h00000001},
    {IMM_OP, 3'b011, 1'b0, 3'd7, 3'd1, 3'd0, 32'h00000200, 32'h00000001},
    {IMM_OP, 3'b100, 1'b0, 3'd6, 3'd5, 3'd0, 32'h000000ff, 32'h000012cf},
    {IMM_OP, 3'b101, 1'b0, 3'd5, 3'd2, 3'd0, 32'h0000001c, 32'h0000000f},
    {IMM_OP, 3'b101, 1'b1, 3'd5, 3'd2, 3'd0, 32'h00000001, 32'hfffffffd},
    {IMM_OP, 3'b110, 1'b0, 3'd3, 3'd0, 3'd0, 32'h000007f0, 32'h000007f0},
    {IMM_OP, 3'b111, 1'b0, 3'd4, 3'd6, 3'd0, 32'h00000f0f, 32'h0000020f},
    // r0 commits its data but keeps reading zero
    {IMM_OP, 3'b000, 1'b0, 3'd0, 3'd1, 3'd0, 32'h00000007, 32'h0000012a},
    {REG_OP, 3'b000, 1'b0, 3'd1, 3'd0, 3'd3, 32'h00000000, 32'h000007f0},
    // dependent chain through several producers
    {IMM_OP, 3'b000, 1'b0, 3'd2, 3'd1, 3'd0, 32'h00000001, 32'h000007f1},
    {REG_OP, 3'b000, 1'b0, 3'd3, 3'd2, 3'd1, 32'h00000000, 32'h00000fe1},
    {REG_OP, 3'b000, 1'b1, 3'd4, 3'd3, 3'd2, 32'h00000000, 32'h000007f0},
    {REG_OP, 3'b100, 1'b0, 3'd5, 3'd4, 3'd3, 32'h00000000, 32'h00000811},
    {REG_OP, 3'b001, 1'b0, 3'd6, 3'd5, 3'd4, 32'h00000000, 32'h08110000},
    {REG_OP, 3'b110, 1'b0, 3'd7, 3'd6, 3'd5, 32'h00000000, 32'h08110811},
    {REG_OP, 3'b000, 1'b0, 3'd0, 3'd7, 3'd7, 32'h00000000, 32'h10221022},
    {REG_OP, 3'b000, 1'b1, 3'd1, 3'd7, 3'd0, 32'h00000000, 32'h08110811},
    {REG_OP, 3'b111, 1'b0, 3'd2, 3'd1, 3'd6, 32'h00000000, 32'h08110000},
    {IMM_OP, 3'b101, 1'b1, 3'd3, 3'd6, 3'd0, 32'h00000004, 32'h00811000},
    {REG_OP, 3'b000, 1'b0, 3'd4, 3'd3, 3'd3, 32'h00000000, 32'h01022000}
};

// ==== bench/tb_tomasulo_core.sv ====
`timescale 1ns/1ps
`include "tomasulo_cfg.svh"

module tb_tomasulo_core;
    import tomasulo_pkg::*;

    `include "tomasulo_vectors.svh"

    localparam int CLK_PERIOD = 20;

    logic             clk;
    logic             rst;
    logic             instr_req;
    instr_t           instr;
    logic             instr_ack;
    commit_t          commit;
    int               commits;
    // next expected commit
    instr_t           exp_word;
    logic [`XLEN-1:0] exp_data;

    tomasulo_core tomasulo_core_inst (
        .clk       (clk),
        .rst       (rst),
        .instr_req (instr_req),
        .instr     (instr),
        .instr_ack (instr_ack),
        .commit    (commit)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic check_value(input string name, input logic [`XLEN-1:0] got,
                               input logic [`XLEN-1:0] exp);
        if (got !== exp) begin
            $display("** Error: %s is %h, expected %h", name, got, exp);
            $display("TEST FAILED");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // four-phase req/ack handshake for one instruction
    task automatic send_instr(input instr_t word);
        instr     = word;
        instr_req = 1'b1;
        // ack of the accept cycle seen on the falling edge
        do @(negedge clk); while (instr_ack !== 1'b1);
        @(posedge clk);
        #1 instr_req = 1'b0;
        // registered ack drops one edge after req goes low
        do begin
            @(posedge clk);
            #1;
        end while (instr_ack !== 1'b0);
    endtask

    // each retirement checked against the next table row
    always @(negedge clk) begin
        if (commit.valid === 1'b1) begin
            if (commits >= NUM_VEC) begin
                $display("commit seen after the whole table had retired");
                $display("TEST FAILED");
                $fatal(1, "extra commit");
            end else begin
                {exp_word, exp_data} = vectors[commits];
                check_value("commit.rd", commit.rd, exp_word.rd);
                check_value("commit.data", commit.data, exp_data);
                commits++;
            end
        end
    end

    // stall guard over reset and idle window plus 40 cycles per row
    initial begin
        #(CLK_PERIOD * (20 + 40 * NUM_VEC));
        $display("commits stalled, only %0d of %0d retired", commits, NUM_VEC);
        $display("TEST FAILED");
        $fatal(1, "timeout");
    end

    initial begin
        instr_t           word;
        int unsigned      gap;
        gap       = $urandom(32'h8738);
        clk       = 1'b0;
        rst       = 1'b1;
        instr_req = 1'b0;
        instr     = '0;
        commits   = 0;
        repeat (10) @(posedge clk);
        #1 rst = 1'b0;
        // idle core shows no ack and no commit
        repeat (5) begin
            @(negedge clk);
            check_value("instr_ack", instr_ack, 1'b0);
            check_value("commit.valid", commit.valid, 1'b0);
        end
        @(posedge clk);
        #1;
        for (int i = 0; i < NUM_VEC; i++) begin
            word = vectors[i][VEC_W-1:`XLEN];
            send_instr(word);
            // mostly back to back with a short pause now and then
            gap = ($urandom % 4 == 0) ? $urandom % 5 : 0;
            #(CLK_PERIOD * gap);
        end
        wait (commits == NUM_VEC);
        // room for a stray extra commit to show up
        repeat (10) @(posedge clk);
        $display("TEST PASSED");
        $finish;
    end

endmodule : tb_tomasulo_core

// ==== vlog.f ====
+incdir+hdl
+incdir+bench
hdl/tomasulo_pkg.sv
hdl/dispatch_unit.sv
hdl/reservation_station.sv
hdl/reorder_buffer.sv
hdl/alu_unit.sv
hdl/tomasulo_core.sv
bench/tb_tomasulo_core.sv
